// ==== exe_pkg.sv ====
package exe_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // return address distance from the branch pc
    localparam word_t link_offset = 32'd4;

    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_sll,
        op_srl,
        op_sra,
        op_mul,
        op_mulh,
        op_mulhu,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_b,
        op_bl,
        op_jirl
    } exe_op_t;

    function automatic logic is_alu(input exe_op_t op);
        return (op >= op_add) && (op <= op_sra);
    endfunction

    function automatic logic is_mul(input exe_op_t op);
        return (op == op_mul) || (op == op_mulh) || (op == op_mulhu);
    endfunction

    function automatic logic is_branch(input exe_op_t op);
        return (op >= op_beq) && (op <= op_jirl);
    endfunction

endpackage

// ==== exe_alu.sv ====
`timescale 1ns/1ps

module exe_alu (
    input  exe_pkg::exe_op_t op,
    input  exe_pkg::word_t   a,
    input  exe_pkg::word_t   b,
    output exe_pkg::word_t   result
);

    import exe_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shift amount from the low bits only
    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            op_add:  result = a + b;
            op_sub:  result = a - b;
            op_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            op_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            op_nor:  result = ~(a | b);
            op_sll:  result = a << shamt;
            op_srl:  result = a >> shamt;
            op_sra:  result = word_t'($signed(a) >>> shamt);
            // multiply and branch ops are handled elsewhere
            default: result = '0;
        endcase
    end

endmodule

// ==== exe_branch.sv ====
`timescale 1ns/1ps

module exe_branch (
    input  exe_pkg::exe_op_t op,
    input  exe_pkg::word_t   pc,
    input  exe_pkg::word_t   pc_next,
    input  exe_pkg::word_t   src0,
    input  exe_pkg::word_t   src1,
    input  exe_pkg::word_t   imm,
    output exe_pkg::word_t   link,
    output exe_pkg::word_t   next_pc,
    output logic             mispredict
);

    import exe_pkg::*;

    logic  equal;
    logic  lt_signed;
    logic  lt_unsigned;
    logic  taken;
    word_t target;

    assign equal       = src0 == src1;
    assign lt_signed   = $signed(src0) < $signed(src1);
    assign lt_unsigned = src0 < src1;

    always_comb begin
        case (op)
            op_beq:  taken = equal;
            op_bne:  taken = !equal;
            op_blt:  taken = lt_signed;
            op_bge:  taken = !lt_signed;
            op_bltu: taken = lt_unsigned;
            op_bgeu: taken = !lt_unsigned;
            // unconditional forms
            op_b,
            op_bl,
            op_jirl: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // register-indirect target only for jirl
    assign target = (op == op_jirl) ? src0 + imm : pc + imm;

    // fall-through pc doubles as the link value
    assign link    = pc + link_offset;
    assign next_pc = taken ? target : link;

    // top level qualifies this with the branch class
    assign mispredict = next_pc != pc_next;

endmodule

// ==== exe_mul.sv ====
`timescale 1ns/1ps

module exe_mul (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             advance,
    input  exe_pkg::exe_op_t op,
    input  exe_pkg::word_t   a,
    input  exe_pkg::word_t   b,
    output exe_pkg::word_t   result
);

    import exe_pkg::*;

    logic        op_signed;
    logic        a_ext;
    logic        b_ext;
    logic [31:0] pp_ll_d;
    logic [31:0] pp_lh_d;
    logic [31:0] pp_hl_d;
    logic [31:0] pp_hh_d;
    word_t       corr_d;
    logic [31:0] pp_ll_q;
    logic [31:0] pp_lh_q;
    logic [31:0] pp_hl_q;
    logic [31:0] pp_hh_q;
    word_t       corr_q;
    exe_op_t     op_q;
    logic [63:0] product;

    // only mulhu treats operands as unsigned
    assign op_signed = (op == op_mul) || (op == op_mulh);

    // bit 32 of each extended operand
    assign a_ext = op_signed && a[31];
    assign b_ext = op_signed && b[31];

    assign pp_ll_d = {16'b0, a[15:0]} * {16'b0, b[15:0]};
    assign pp_lh_d = {16'b0, a[15:0]} * {16'b0, b[31:16]};
    assign pp_hl_d = {16'b0, a[31:16]} * {16'b0, b[15:0]};
    assign pp_hh_d = {16'b0, a[31:16]} * {16'b0, b[31:16]};

    // a negative operand takes the other one off the high word
    assign corr_d = (a_ext ? b : '0) + (b_ext ? a : '0);

    always_ff @(posedge clk) begin
        if (advance) begin
            pp_ll_q <= pp_ll_d;
            pp_lh_q <= pp_lh_d;
            pp_hl_q <= pp_hl_d;
            pp_hh_q <= pp_hh_d;
            corr_q  <= corr_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= op_mul;
        end else if (advance) begin
            op_q <= op;
        end
    end

    // second cycle: sum the partials into the full product
    assign product = {pp_hh_q, pp_ll_q}
                   + {16'b0, pp_lh_q, 16'b0}
                   + {16'b0, pp_hl_q, 16'b0}
                   - {corr_q, 32'b0};

    assign result = (op_q == op_mul) ? product[31:0] : product[63:32];

endmodule

// ==== exe_bypass.sv ====
`timescale 1ns/1ps

module exe_bypass (
    input  exe_pkg::reg_addr_t rj0,
    input  exe_pkg::reg_addr_t rk0,
    input  exe_pkg::reg_addr_t rj1,
    input  exe_pkg::reg_addr_t rk1,
    input  logic               en0,
    input  logic               en1,
    input  exe_pkg::word_t     rj0_data,
    input  exe_pkg::word_t     rk0_data,
    input  exe_pkg::word_t     rj1_data,
    input  exe_pkg::word_t     rk1_data,
    input  logic               mid_en0,
    input  logic               mid_en1,
    input  logic               mid_is_mul0,
    input  exe_pkg::reg_addr_t mid_rd0,
    input  exe_pkg::reg_addr_t mid_rd1,
    input  exe_pkg::word_t     mid_data0,
    input  exe_pkg::word_t     mid_data1,
    input  logic               out_en0,
    input  logic               out_en1,
    input  exe_pkg::reg_addr_t out_rd0,
    input  exe_pkg::reg_addr_t out_rd1,
    input  exe_pkg::word_t     out_data0,
    input  exe_pkg::word_t     out_data1,
    output exe_pkg::word_t     src_j0,
    output exe_pkg::word_t     src_k0,
    output exe_pkg::word_t     src_j1,
    output exe_pkg::word_t     src_k1,
    output logic               stall
);

    import exe_pkg::*;

    logic mul_pending;
    logic hit0;
    logic hit1;

    // youngest producer wins; slot 1 is younger than slot 0
    function automatic word_t forward(input reg_addr_t src, input word_t rf_data);
        word_t sel;
        if (src == '0) begin
            sel = '0;
        end else if (mid_en1 && (mid_rd1 == src)) begin
            sel = mid_data1;
        end else if (mid_en0 && !mid_is_mul0 && (mid_rd0 == src)) begin
            sel = mid_data0;
        end else if (out_en1 && (out_rd1 == src)) begin
            sel = out_data1;
        end else if (out_en0 && (out_rd0 == src)) begin
            sel = out_data0;
        end else begin
            sel = rf_data;
        end
        return sel;
    endfunction

    always_comb begin
        src_j0 = forward(rj0, rj0_data);
        src_k0 = forward(rk0, rk0_data);
        src_j1 = forward(rj1, rj1_data);
        src_k1 = forward(rk1, rk1_data);
    end

    // multiply result is not ready until it reaches out
    assign mul_pending = mid_en0 && mid_is_mul0 && (mid_rd0 != '0);
    assign hit0        = en0 && ((rj0 == mid_rd0) || (rk0 == mid_rd0));
    assign hit1        = en1 && ((rj1 == mid_rd0) || (rk1 == mid_rd0));
    assign stall       = mul_pending && (hit0 || hit1);

endmodule

// ==== exe_stage.sv ====
`timescale 1ns/1ps

module exe_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en0,
    input  exe_pkg::exe_op_t   op0,
    input  exe_pkg::reg_addr_t rd0,
    input  exe_pkg::reg_addr_t rj0,
    input  exe_pkg::reg_addr_t rk0,
    input  exe_pkg::word_t     imm0,
    input  logic               use_imm0,
    input  exe_pkg::word_t     rj_data0,
    input  exe_pkg::word_t     rk_data0,
    input  exe_pkg::word_t     pc,
    input  exe_pkg::word_t     pc_next,
    input  logic               en1,
    input  exe_pkg::exe_op_t   op1,
    input  exe_pkg::reg_addr_t rd1,
    input  exe_pkg::reg_addr_t rj1,
    input  exe_pkg::reg_addr_t rk1,
    input  exe_pkg::word_t     imm1,
    input  logic               use_imm1,
    input  exe_pkg::word_t     rj_data1,
    input  exe_pkg::word_t     rk_data1,
    output logic               wb_en0,
    output exe_pkg::reg_addr_t wb_addr0,
    output exe_pkg::word_t     wb_data0,
    output logic               wb_en1,
    output exe_pkg::reg_addr_t wb_addr1,
    output exe_pkg::word_t     wb_data1,
    output logic               stall,
    output logic               flush,
    output exe_pkg::word_t     correct_pc
);

    import exe_pkg::*;

    logic      accept;
    logic      is_link0;
    logic      writes_rd0;
    logic      branch_go;
    logic      mul_go;
    word_t     src_j0;
    word_t     src_k0;
    word_t     src_j1;
    word_t     src_k1;
    word_t     alu_b0;
    word_t     alu_b1;
    word_t     alu_res0;
    word_t     alu_res1;
    word_t     link;
    word_t     next_pc;
    logic      mispredict;
    word_t     mul_res;
    logic      mid_en0;
    logic      mid_en1;
    logic      mid_is_mul0;
    reg_addr_t mid_rd0;
    reg_addr_t mid_rd1;
    word_t     mid_data0;
    word_t     mid_data1;

    // bundle enters the pipe only on a clean edge
    assign accept     = !stall && !flush;
    assign is_link0   = (op0 == op_bl) || (op0 == op_jirl);
    assign writes_rd0 = is_alu(op0) || is_mul(op0) || is_link0;
    assign branch_go  = accept && en0 && is_branch(op0);
    assign mul_go     = accept && en0 && is_mul(op0);

    assign alu_b0 = use_imm0 ? imm0 : src_k0;
    assign alu_b1 = use_imm1 ? imm1 : src_k1;

    exe_bypass u_bypass (
        .rj0         (rj0),
        .rk0         (rk0),
        .rj1         (rj1),
        .rk1         (rk1),
        .en0         (en0),
        .en1         (en1),
        .rj0_data    (rj_data0),
        .rk0_data    (rk_data0),
        .rj1_data    (rj_data1),
        .rk1_data    (rk_data1),
        .mid_en0     (mid_en0),
        .mid_en1     (mid_en1),
        .mid_is_mul0 (mid_is_mul0),
        .mid_rd0     (mid_rd0),
        .mid_rd1     (mid_rd1),
        .mid_data0   (mid_data0),
        .mid_data1   (mid_data1),
        .out_en0     (wb_en0),
        .out_en1     (wb_en1),
        .out_rd0     (wb_addr0),
        .out_rd1     (wb_addr1),
        .out_data0   (wb_data0),
        .out_data1   (wb_data1),
        .src_j0      (src_j0),
        .src_k0      (src_k0),
        .src_j1      (src_j1),
        .src_k1      (src_k1),
        .stall       (stall)
    );

    exe_alu u_alu0 (
        .op     (op0),
        .a      (src_j0),
        .b      (alu_b0),
        .result (alu_res0)
    );

    exe_alu u_alu1 (
        .op     (op1),
        .a      (src_j1),
        .b      (alu_b1),
        .result (alu_res1)
    );

    exe_branch u_branch (
        .op         (op0),
        .pc         (pc),
        .pc_next    (pc_next),
        .src0       (src_j0),
        .src1       (src_k0),
        .imm        (imm0),
        .link       (link),
        .next_pc    (next_pc),
        .mispredict (mispredict)
    );

    exe_mul u_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (mul_go),
        .op      (op0),
        .a       (src_j0),
        .b       (src_k0),
        .result  (mul_res)
    );

    // mid: a stall or flush loads a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_en0     <= 1'b0;
            mid_en1     <= 1'b0;
            mid_is_mul0 <= 1'b0;
        end else begin
            mid_en0     <= accept && en0 && writes_rd0;
            mid_en1     <= accept && en1 && is_alu(op1);
            mid_is_mul0 <= mul_go;
        end
    end

    always_ff @(posedge clk) begin
        mid_rd0   <= rd0;
        mid_rd1   <= rd1;
        mid_data0 <= is_link0 ? link : alu_res0;
        mid_data1 <= alu_res1;
    end

    // out: slot 1 behind a mispredicted branch is dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en0 <= 1'b0;
            wb_en1 <= 1'b0;
        end else begin
            wb_en0 <= mid_en0;
            wb_en1 <= mid_en1 && !flush;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr0 <= mid_rd0;
        wb_data0 <= mid_is_mul0 ? mul_res : mid_data0;
        wb_addr1 <= mid_rd1;
        wb_data1 <= mid_data1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flush <= 1'b0;
        end else begin
            flush <= branch_go && mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (branch_go) begin
            correct_pc <= next_pc;
        end
    end

endmodule

// ==== tb_exe_model.svh ====
`ifndef TB_EXE_MODEL_SVH
`define TB_EXE_MODEL_SVH

typedef struct {
    int        cyc;
    int        slot;
    reg_addr_t addr;
    word_t     data;
} wb_entry_t;

// program-order state, updated when a bundle is accepted
word_t     model_rf [0:31];
// what issue reads, updated only from uut writebacks
word_t     dut_rf [0:31];
wb_entry_t wb_queue [$];

function automatic word_t read_model(input reg_addr_t r);
    return (r == '0) ? '0 : model_rf[r];
endfunction

function automatic word_t alu_model(input exe_op_t op, input word_t a, input word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        op_add:  return a + b;
        op_sub:  return a - b;
        op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        op_sltu: return (a < b) ? 32'd1 : 32'd0;
        op_and:  return a & b;
        op_or:   return a | b;
        op_xor:  return a ^ b;
        op_nor:  return ~(a | b);
        op_sll:  return a << sh;
        op_srl:  return a >> sh;
        op_sra:  return word_t'($signed(a) >>> sh);
        default: return '0;
    endcase
endfunction

function automatic word_t mul_model(input exe_op_t op, input word_t a, input word_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    if (op == op_mulhu) begin
        ea = {32'b0, a};
        eb = {32'b0, b};
    end else begin
        ea = {{32{a[31]}}, a};
        eb = {{32{b[31]}}, b};
    end
    // low 64 bits of the product are the same for both interpretations
    p = ea * eb;
    return (op == op_mul) ? p[31:0] : p[63:32];
endfunction

function automatic word_t branch_next(input exe_op_t op, input word_t pc, input word_t a,
                                      input word_t b, input word_t imm);
    logic  taken;
    word_t target;
    case (op)
        op_beq:  taken = (a == b);
        op_bne:  taken = (a != b);
        op_blt:  taken = ($signed(a) < $signed(b));
        op_bge:  taken = ($signed(a) >= $signed(b));
        op_bltu: taken = (a < b);
        op_bgeu: taken = (a >= b);
        op_b, op_bl, op_jirl: taken = 1'b1;
        default: taken = 1'b0;
    endcase
    target = (op == op_jirl) ? a + imm : pc + imm;
    return taken ? target : pc + link_offset;
endfunction

task automatic compare_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("Error at %0t: %s expected %h, got %h", $time, what, exp, got);
        stop_failed();
    end
endtask

task automatic compare_addr(input string what, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
        $display("Error at %0t: %s expected r%0d, got r%0d", $time, what, exp, got);
        stop_failed();
    end
endtask

task automatic compare_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Error at %0t: %s expected %b, got %b", $time, what, exp, got);
        stop_failed();
    end
endtask

`endif

// ==== tb_exe.sv ====
`timescale 1ns/1ps

module tb_exe;

    import exe_pkg::*;

    localparam int n_bundles = 400;

    logic clk, rst_n;
    logic en0, en1, use_imm0, use_imm1;
    exe_op_t op0, op1;
    reg_addr_t rd0, rj0, rk0, rd1, rj1, rk1;
    word_t imm0, imm1, rj_data0, rk_data0, rj_data1, rk_data1, pc, pc_next;
    logic wb_en0, wb_en1, stall, flush;
    reg_addr_t wb_addr0, wb_addr1;
    word_t wb_data0, wb_data1, correct_pc;

    // bundle currently presented to the DUT
    logic b_en0, b_en1, b_use_imm0, b_use_imm1;
    exe_op_t b_op0, b_op1;
    reg_addr_t b_rd0, b_rj0, b_rk0, b_rd1, b_rj1, b_rk1;
    word_t b_imm0, b_imm1, b_pc, b_pc_next;

    int cyc;
    int accepted;
    reg_addr_t mid_mul_rd;
    logic exp_flush;
    word_t exp_cpc;

    exe_stage uut (.*);

    task automatic stop_failed();
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        stop_failed();
    endtask

    `include "tb_exe_model.svh"

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (n_bundles * 4 + 20) @(posedge clk);
        report_problem("watchdog timeout, bundles did not all retire");
    end

    function automatic reg_addr_t pick_reg(input int lo);
        return reg_addr_t'(lo + ($urandom % (8 - lo)));
    endfunction

    task automatic gen_bundle();
        int r;
        logic writes0;
        word_t npc;
        r = $urandom % 4;
        b_en0 = ($urandom % 10) != 0;
        b_rd0 = pick_reg(1);
        b_rj0 = pick_reg(0);
        b_rk0 = pick_reg(0);
        b_imm0 = $urandom;
        b_use_imm0 = 1'b0;
        b_pc = word_t'($urandom) & 32'hffff_fffc;
        if (r < 2) begin
            b_op0 = exe_op_t'($urandom % 11);
            b_use_imm0 = ($urandom % 2) != 0;
        end else if (r == 2) begin
            b_op0 = exe_op_t'(11 + $urandom % 3);
        end else begin
            b_op0 = exe_op_t'(14 + $urandom % 9);
            b_imm0 = word_t'(32'($urandom % 256) << 2);
        end
        npc = b_pc + link_offset;
        if (is_branch(b_op0)) begin
            npc = branch_next(b_op0, b_pc, read_model(b_rj0), read_model(b_rk0), b_imm0);
        end
        // about half the predictions are wrong
        b_pc_next = (($urandom % 2) != 0) ? npc : npc + 32'h40;
        writes0 = b_en0 && (is_alu(b_op0) || is_mul(b_op0) || b_op0 == op_bl
                  || b_op0 == op_jirl);
        // slot 1 stays independent of slot 0
        b_en1 = ($urandom % 5) != 0;
        b_op1 = exe_op_t'($urandom % 11);
        b_rd1 = pick_reg(1);
        b_imm1 = $urandom;
        b_use_imm1 = ($urandom % 2) != 0;
        do b_rj1 = pick_reg(0); while (writes0 && b_rj1 == b_rd0);
        do b_rk1 = pick_reg(0); while (writes0 && b_rk1 == b_rd0);
    endtask

    task automatic drive_bundle();
        en0 <= b_en0;
        op0 <= b_op0;
        rd0 <= b_rd0;
        rj0 <= b_rj0;
        rk0 <= b_rk0;
        imm0 <= b_imm0;
        use_imm0 <= b_use_imm0;
        pc <= b_pc;
        pc_next <= b_pc_next;
        en1 <= b_en1;
        op1 <= b_op1;
        rd1 <= b_rd1;
        rj1 <= b_rj1;
        rk1 <= b_rk1;
        imm1 <= b_imm1;
        use_imm1 <= b_use_imm1;
        // register file read is refreshed even for a held bundle
        rj_data0 <= (b_rj0 == '0) ? '0 : dut_rf[b_rj0];
        rk_data0 <= (b_rk0 == '0) ? '0 : dut_rf[b_rk0];
        rj_data1 <= (b_rj1 == '0) ? '0 : dut_rf[b_rj1];
        rk_data1 <= (b_rk1 == '0) ? '0 : dut_rf[b_rk1];
    endtask

    task automatic push_wb(input int slot, input reg_addr_t addr, input word_t data);
        wb_entry_t e;
        e.cyc = cyc + 2;
        e.slot = slot;
        e.addr = addr;
        e.data = data;
        wb_queue.push_back(e);
        model_rf[addr] = data;
    endtask

    task automatic check_outputs();
        wb_entry_t e;
        logic got0;
        logic got1;
        got0 = 1'b0;
        got1 = 1'b0;
        while (wb_queue.size() > 0 && wb_queue[0].cyc == cyc) begin
            e = wb_queue.pop_front();
            if (e.slot == 0) begin
                compare_bit("wb_en0", wb_en0, 1'b1);
                compare_addr("wb_addr0", wb_addr0, e.addr);
                compare_word("wb_data0", wb_data0, e.data);
                got0 = 1'b1;
            end else begin
                compare_bit("wb_en1", wb_en1, 1'b1);
                compare_addr("wb_addr1", wb_addr1, e.addr);
                compare_word("wb_data1", wb_data1, e.data);
                got1 = 1'b1;
            end
        end
        compare_bit("wb_en0", wb_en0, got0);
        compare_bit("wb_en1", wb_en1, got1);
        if (wb_en0) dut_rf[wb_addr0] = wb_data0;
        if (wb_en1) dut_rf[wb_addr1] = wb_data1;
        compare_bit("flush", flush, exp_flush);
        if (exp_flush) compare_word("correct_pc", correct_pc, exp_cpc);
    endtask

    task automatic apply_bundle();
        word_t a0, b0, a1, b1, npc;
        logic mis;
        a0 = read_model(b_rj0);
        b0 = read_model(b_rk0);
        a1 = read_model(b_rj1);
        b1 = b_use_imm1 ? b_imm1 : read_model(b_rk1);
        mis = 1'b0;
        if (b_en0) begin
            if (is_mul(b_op0)) begin
                push_wb(0, b_rd0, mul_model(b_op0, a0, b0));
                mid_mul_rd = b_rd0;
            end else if (is_branch(b_op0)) begin
                npc = branch_next(b_op0, b_pc, a0, b0, b_imm0);
                mis = npc != b_pc_next;
                exp_cpc = mis ? npc : exp_cpc;
                if (b_op0 == op_bl || b_op0 == op_jirl) push_wb(0, b_rd0, b_pc + link_offset);
            end else begin
                push_wb(0, b_rd0, alu_model(b_op0, a0, b_use_imm0 ? b_imm0 : b0));
            end
        end
        if (b_en1 && !mis) push_wb(1, b_rd1, alu_model(b_op1, a1, b1));
        exp_flush = mis;
    endtask

    task automatic decide();
        logic exp_stall;
        logic was_flush;
        exp_stall = (mid_mul_rd != '0)
                    && ((b_en0 && (b_rj0 == mid_mul_rd || b_rk0 == mid_mul_rd))
                    || (b_en1 && (b_rj1 == mid_mul_rd || b_rk1 == mid_mul_rd)));
        compare_bit("stall", stall, exp_stall);
        was_flush = flush;
        mid_mul_rd = '0;
        exp_flush = 1'b0;
        if (!stall && !was_flush) begin
            apply_bundle();
            accepted++;
            gen_bundle();
        end else if (was_flush) begin
            // discarded bundle is replaced
            gen_bundle();
        end
    endtask

    initial begin
        void'($urandom(32'hfecb_b36a));
        {en0, en1, use_imm0, use_imm1} = '0;
        {op0, op1} = {op_add, op_add};
        {rd0, rj0, rk0, rd1, rj1, rk1} = '0;
        {imm0, imm1, rj_data0, rk_data0, rj_data1, rk_data1, pc, pc_next} = '0;
        rst_n = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = (i == 0) ? '0 : $urandom;
            dut_rf[i] = model_rf[i];
        end
        cyc = 0;
        accepted = 0;
        mid_mul_rd = '0;
        exp_flush = 1'b0;
        exp_cpc = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        gen_bundle();
        while (accepted < n_bundles) begin
            @(posedge clk);
            drive_bundle();
            @(negedge clk);
            cyc++;
            check_outputs();
            decide();
        end
        repeat (4) begin
            @(posedge clk);
            en0 <= 1'b0;
            en1 <= 1'b0;
            @(negedge clk);
            cyc++;
            check_outputs();
            exp_flush = 1'b0;
        end
        if (wb_queue.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            report_problem("expected writebacks never appeared");
        end
    end

endmodule

// ==== src.f ====
+incdir+.
exe_pkg.sv
exe_alu.sv
exe_branch.sv
exe_mul.sv
exe_bypass.sv
exe_stage.sv
tb_exe.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f src.f --top-module tb_exe -o tb_exe_sim
out=$(./obj_dir/tb_exe_sim) || {
    echo "$out"
    exit 1
}
echo "$out"
echo "$out" | grep -q "All checks passed"
